//--- all.f
+incdir+verilog
verilog/ifetch_pkg.sv
verilog/mem_bus_if.sv
verilog/l1_icache.sv
verilog/icache_miss_ctrl.sv
verilog/load_port.sv
verilog/bus_arbiter.sv
verilog/ifetch_top.sv
verif/tb_mem_model.sv
verif/tb_ifetch.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ifetch -f all.f \
	--Mdir obj_dir -o sim_ifetch

./obj_dir/sim_ifetch > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0

//--- verif/tb_ifetch.sv
`include "ifetch_macros.svh"

module tb_ifetch;
	import ifetch_pkg::*;

	// About 30 handshakes, a fill is at most 4 beats of 8 cycles plus a few
	// cycles of lookup and reply, so well under 1500 cycles in total
	localparam int TIMEOUT_CYCLES = 4000;
	// Sampling edge plus registered read plus reply
	localparam int HIT_LATENCY = 3;

	logic                  clk;
	logic                  rst_i;
	logic                  fetch_req_i;
	logic [`IF_ADR_W-1:0]  fetch_adr_i;
	logic                  fetch_ack_o;
	logic [`IF_WORD_W-1:0] fetch_data_o;
	mem_err_e              fetch_err_o;
	logic                  ld_req_i;
	logic [`IF_ADR_W-1:0]  ld_adr_i;
	logic                  ld_ack_o;
	logic [`IF_WORD_W-1:0] ld_data_o;
	mem_err_e              ld_err_o;
	logic                  inv_req_i;
	logic [`IF_ADR_W-1:0]  inv_adr_i;
	logic                  inv_ack_o;
	logic [31:0]           miss_count_o;
	logic                  mem_req;
	logic [`IF_ADR_W-1:0]  mem_adr;
	logic                  mem_ack;
	logic [`IF_WORD_W-1:0] mem_rdata;
	mem_err_e              mem_err;

	int err_count   = 0;
	int check_total = 0;
	int cycle_count = 0;

	ifetch_top DUT (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.fetch_ack_o  (fetch_ack_o),
		.fetch_data_o (fetch_data_o),
		.fetch_err_o  (fetch_err_o),
		.ld_req_i     (ld_req_i),
		.ld_adr_i     (ld_adr_i),
		.ld_ack_o     (ld_ack_o),
		.ld_data_o    (ld_data_o),
		.ld_err_o     (ld_err_o),
		.inv_req_i    (inv_req_i),
		.inv_adr_i    (inv_adr_i),
		.inv_ack_o    (inv_ack_o),
		.miss_count_o (miss_count_o),
		.mem_req_o    (mem_req),
		.mem_adr_o    (mem_adr),
		.mem_ack_i    (mem_ack),
		.mem_rdata_i  (mem_rdata),
		.mem_err_i    (mem_err)
	);

	tb_mem_model mem_model (
		.clk         (clk),
		.rst_i       (rst_i),
		.mem_req_i   (mem_req),
		.mem_adr_i   (mem_adr),
		.mem_ack_o   (mem_ack),
		.mem_rdata_o (mem_rdata),
		.mem_err_o   (mem_err)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Stops a run whose handshake never completes
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles, a handshake hung",
				TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_total, err_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Expected memory word, aligned to the word
	function automatic logic [`IF_WORD_W-1:0] mem_word(input logic [`IF_ADR_W-1:0] adr);
		logic [`IF_WORD_W-1:0] a;
		a = {{(`IF_WORD_W-`IF_ADR_W){1'b0}}, adr[`IF_ADR_W-1:2], 2'b00};
		return a * 32'd3 + 32'h0000_1000;
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_word(input string name, input logic [`IF_WORD_W-1:0] got,
		input logic [`IF_WORD_W-1:0] exp);
		check_total++;
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_err(input string name, input mem_err_e got, input mem_err_e exp);
		check_total++;
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_total++;
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_total++;
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	// ======================================================================
	// Four-phase port drivers
	// ======================================================================
	task automatic fetch_word(input logic [`IF_ADR_W-1:0] adr,
		output logic [`IF_WORD_W-1:0] data, output mem_err_e err, output int cycles);
		@(negedge clk);
		fetch_adr_i = adr;
		fetch_req_i = 1'b1;
		@(negedge clk);
		cycles = 1;
		while (!fetch_ack_o) begin
			@(negedge clk);
			cycles++;
		end
		data = fetch_data_o;
		err  = fetch_err_o;
		fetch_req_i = 1'b0;
		@(negedge clk);
		while (fetch_ack_o)
			@(negedge clk);
	endtask

	task automatic load_word(input logic [`IF_ADR_W-1:0] adr,
		output logic [`IF_WORD_W-1:0] data, output mem_err_e err);
		@(negedge clk);
		ld_adr_i = adr;
		ld_req_i = 1'b1;
		@(negedge clk);
		while (!ld_ack_o)
			@(negedge clk);
		data = ld_data_o;
		err  = ld_err_o;
		ld_req_i = 1'b0;
		@(negedge clk);
		while (ld_ack_o)
			@(negedge clk);
	endtask

	task automatic invalidate_line(input logic [`IF_ADR_W-1:0] adr);
		@(negedge clk);
		inv_adr_i = adr;
		inv_req_i = 1'b1;
		@(negedge clk);
		while (!inv_ack_o)
			@(negedge clk);
		inv_req_i = 1'b0;
		@(negedge clk);
		while (inv_ack_o)
			@(negedge clk);
	endtask

	// Fetch, then check word, code and how far the miss counter moved
	task automatic fetch_and_check(input logic [`IF_ADR_W-1:0] adr,
		input logic [`IF_WORD_W-1:0] exp_word, input mem_err_e exp_err,
		input int count_step, output int cycles);
		logic [31:0]           count_before;
		logic [`IF_WORD_W-1:0] data;
		mem_err_e              err;
		count_before = miss_count_o;
		fetch_word(adr, data, err, cycles);
		check_word("fetch_data_o", data, exp_word);
		check_err("fetch_err_o", err, exp_err);
		check_count("miss_count_o", miss_count_o, count_before + 32'(count_step));
	endtask

	// Word is only defined for a clean load
	task automatic load_and_check(input logic [`IF_ADR_W-1:0] adr, input mem_err_e exp_err);
		logic [`IF_WORD_W-1:0] data;
		mem_err_e              err;
		load_word(adr, data, err);
		check_err("ld_err_o", err, exp_err);
		if (exp_err == MEM_OK)
			check_word("ld_data_o", data, mem_word(adr));
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================
	task automatic test_reset_state();
		check_bit("fetch_ack_o", fetch_ack_o, 1'b0);
		check_bit("ld_ack_o", ld_ack_o, 1'b0);
		check_bit("inv_ack_o", inv_ack_o, 1'b0);
		check_bit("mem_req_o", mem_req, 1'b0);
		check_count("miss_count_o", miss_count_o, 32'd0);
	endtask

	task automatic test_fetch_miss_hit();
		int cycles;
		fetch_and_check(16'h0120, mem_word(16'h0120), MEM_OK, 1, cycles);
		// Same line, now a hit
		fetch_and_check(16'h0128, mem_word(16'h0128), MEM_OK, 0, cycles);
		check_count("fetch hit latency", 32'(cycles), 32'(HIT_LATENCY));
	endtask

	task automatic test_fetch_error_regions();
		int cycles;
		fetch_and_check(16'hF040, `IF_NOP_WORD, MEM_BUS_ERR, 1, cycles);
		fetch_and_check(16'hF040, `IF_NOP_WORD, MEM_BUS_ERR, 0, cycles);
		fetch_and_check(16'hE080, `IF_NOP_WORD, MEM_PROT_ERR, 1, cycles);
		fetch_and_check(16'hE084, `IF_NOP_WORD, MEM_PROT_ERR, 0, cycles);
	endtask

	task automatic test_invalidate();
		int cycles;
		invalidate_line(16'h0120);
		fetch_and_check(16'h0124, mem_word(16'h0124), MEM_OK, 1, cycles);
		// Same index, other tag, the cached line stays
		invalidate_line(16'h3120);
		fetch_and_check(16'h012C, mem_word(16'h012C), MEM_OK, 0, cycles);
	endtask

	task automatic test_load_beside_fill();
		int cycles;
		fork
			fetch_and_check(16'h0250, mem_word(16'h0250), MEM_OK, 1, cycles);
			begin
				load_and_check(16'h1004, MEM_OK);
				load_and_check(16'h2000, MEM_OK);
				load_and_check(16'h0A08, MEM_OK);
				load_and_check(16'h3FFC, MEM_OK);
			end
		join
	endtask

	task automatic test_load_error_regions();
		load_and_check(16'hF100, MEM_BUS_ERR);
		load_and_check(16'hE200, MEM_PROT_ERR);
		load_and_check(16'h0010, MEM_OK);
	endtask

	initial begin
		rst_i       = 1'b1;
		fetch_req_i = 1'b0;
		fetch_adr_i = '0;
		ld_req_i    = 1'b0;
		ld_adr_i    = '0;
		inv_req_i   = 1'b0;
		inv_adr_i   = '0;
		repeat (10) @(negedge clk);
		rst_i = 1'b0;
		@(negedge clk);
		test_reset_state();
		test_fetch_miss_hit();
		test_fetch_error_regions();
		test_invalidate();
		test_load_beside_fill();
		test_load_error_regions();
		repeat (4) @(negedge clk);
		$display("Checks: %0d, errors: %0d", check_total, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- verif/tb_mem_model.sv
`include "ifetch_macros.svh"

// Behavioral memory slave on the arbiter pins
// Word at A is A*3 + 0x1000, top nibble F or E gives an error code
module tb_mem_model (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  mem_req_i,
	input  logic [`IF_ADR_W-1:0]  mem_adr_i,
	output logic                  mem_ack_o,
	output logic [`IF_WORD_W-1:0] mem_rdata_o,
	output ifetch_pkg::mem_err_e  mem_err_o
);
	import ifetch_pkg::*;

	// Ack delay source, fixed seed for a repeatable run
	int seed = 60097;
	int rnd;

	logic                  ack_q   = 1'b0;
	logic [`IF_WORD_W-1:0] rdata_q = '0;
	mem_err_e              err_q   = MEM_OK;
	// Beat accepted and waiting out its delay
	logic                  busy_q  = 1'b0;
	logic [1:0]            wait_q  = '0;

	assign mem_ack_o   = ack_q;
	assign mem_rdata_o = rdata_q;
	assign mem_err_o   = err_q;

	always @(posedge clk) begin
		if (rst_i) begin
			ack_q  <= 1'b0;
			busy_q <= 1'b0;
		end else if (ack_q) begin
			// Close the beat once the master lets go
			if (!mem_req_i)
				ack_q <= 1'b0;
		end else if (mem_req_i) begin
			if (!busy_q) begin
				rnd = $random(seed);
				wait_q <= rnd[1:0];
				busy_q <= 1'b1;
			end else if (wait_q == 2'd0) begin
				ack_q   <= 1'b1;
				busy_q  <= 1'b0;
				rdata_q <= {{(`IF_WORD_W-`IF_ADR_W){1'b0}}, mem_adr_i} * 32'd3 + 32'h0000_1000;
				// Region decode on the top nibble
				if (mem_adr_i[`IF_ADR_W-1 -: 4] == 4'hF)
					err_q <= MEM_BUS_ERR;
				else if (mem_adr_i[`IF_ADR_W-1 -: 4] == 4'hE)
					err_q <= MEM_PROT_ERR;
				else
					err_q <= MEM_OK;
			end else begin
				wait_q <= wait_q - 2'd1;
			end
		end
	end

endmodule

//--- verilog/bus_arbiter.sv
`include "ifetch_macros.svh"

module bus_arbiter (
	input  logic      clk,
	input  logic      rst_i,
	mem_bus_if.slave  fill_bus,
	mem_bus_if.slave  ld_bus,
	mem_bus_if.master mem
);
	import ifetch_pkg::*;

	arb_state_e state;
	// Current grant, doubles as last served once idle
	logic gnt_fill_q;
	logic pick_fill;
	logic granted;
	logic fill_sel, ld_sel;
	logic sel_req, sel_lock;

	// Alternate when both ask at once
	assign pick_fill = (fill_bus.req && ld_bus.req) ? !gnt_fill_q : fill_bus.req;

	assign granted  = (state == ARB_GRANT);
	assign fill_sel = granted && gnt_fill_q;
	assign ld_sel   = granted && !gnt_fill_q;
	assign sel_req  = gnt_fill_q ? fill_bus.req : ld_bus.req;
	assign sel_lock = gnt_fill_q ? fill_bus.lock : ld_bus.lock;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state      <= ARB_IDLE;
			gnt_fill_q <= 1'b0;
		end else begin
			case (state)
			ARB_IDLE: begin
				if (fill_bus.req || ld_bus.req) begin
					gnt_fill_q <= pick_fill;
					state      <= ARB_GRANT;
				end
			end
			ARB_GRANT: begin
				// Beat fully closed and no burst lock
				if (!sel_req && !sel_lock && !mem.ack)
					state <= ARB_IDLE;
			end
			default: state <= ARB_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Routing
	// ======================================================================
	assign mem.req  = granted && sel_req;
	assign mem.lock = granted && sel_lock;
	assign mem.adr  = gnt_fill_q ? fill_bus.adr : ld_bus.adr;

	// Responses reach the granted side only
	assign fill_bus.ack   = fill_sel && mem.ack;
	assign fill_bus.rdata = fill_sel ? mem.rdata : '0;
	assign fill_bus.err   = fill_sel ? mem.err : MEM_OK;
	assign ld_bus.ack     = ld_sel && mem.ack;
	assign ld_bus.rdata   = ld_sel ? mem.rdata : '0;
	assign ld_bus.err     = ld_sel ? mem.err : MEM_OK;

endmodule

//--- verilog/icache_miss_ctrl.sv
`include "ifetch_macros.svh"

module icache_miss_ctrl (
	input  logic                     clk,
	input  logic                     rst_i,
	// Processor fetch port
	input  logic                     fetch_req_i,
	input  logic [`IF_ADR_W-1:0]     fetch_adr_i,
	output logic                     fetch_ack_o,
	output logic [`IF_WORD_W-1:0]    fetch_data_o,
	output ifetch_pkg::mem_err_e     fetch_err_o,
	// Line invalidate request
	input  logic                     inv_req_i,
	input  logic [`IF_ADR_W-1:0]     inv_adr_i,
	output logic                     inv_ack_o,
	output logic [31:0]              miss_count_o,
	// L1 array side
	output logic [`IF_ADR_W-1:0]     rd_adr_o,
	input  logic                     rd_hit_i,
	input  logic [`IF_WORD_W-1:0]    rd_data_i,
	input  ifetch_pkg::mem_err_e     rd_err_i,
	output logic                     wr_en_o,
	output logic [`IF_ADR_W-1:0]     wr_adr_o,
	output ifetch_pkg::icache_line_t wr_line_o,
	output logic                     inv_en_o,
	output logic [`IF_ADR_W-1:0]     inv_adr_o,
	// Line fill bus
	mem_bus_if.master                bus
);
	import ifetch_pkg::*;

	localparam int WSEL_W = $clog2(`IF_LINE_WORDS);
	localparam logic [WSEL_W-1:0] LAST_BEAT = WSEL_W'(`IF_LINE_WORDS - 1);

	miss_state_e state;

	// Fetch address, held for lookup and fill
	logic [`IF_ADR_W-1:0] adr_q;
	// Beat counter inside the line
	logic [WSEL_W-1:0]    beat_q;
	logic                 req_q;
	logic                 lock_q;
	// Line being assembled
	logic [`IF_LINE_WORDS-1:0][`IF_WORD_W-1:0] line_words;
	mem_err_e             line_err;

	// Array always looks at the held address
	assign rd_adr_o = adr_q;
	assign wr_adr_o = adr_q;

	// Write once the last ack of the burst has fallen
	assign wr_en_o = (state == MS_WRITE) && !bus.ack;

	// A failed fill stores NOPs with the error code
	always_comb begin
		wr_line_o.err   = line_err;
		wr_line_o.words = line_words;
		if (line_err != MEM_OK)
			wr_line_o.words = {`IF_LINE_WORDS{`IF_NOP_WORD}};
	end

	// Line-aligned burst address, beat selects the word
	assign bus.req  = req_q;
	assign bus.lock = lock_q;
	assign bus.adr  = {adr_q[`IF_ADR_W-1:`IF_OFS_W], beat_q, 2'b00};

	// ======================================================================
	// Miss FSM
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state        <= MS_IDLE;
			fetch_ack_o  <= 1'b0;
			inv_ack_o    <= 1'b0;
			inv_en_o     <= 1'b0;
			req_q        <= 1'b0;
			lock_q       <= 1'b0;
			beat_q       <= '0;
			miss_count_o <= '0;
		end else begin
			inv_en_o <= 1'b0;
			case (state)
			MS_IDLE: begin
				// Invalidate wins over a new fetch
				if (inv_req_i) begin
					inv_adr_o <= inv_adr_i;
					inv_en_o  <= 1'b1;
					state     <= MS_INVAL;
				end else if (fetch_req_i) begin
					adr_q <= fetch_adr_i;
					state <= MS_LOOKUP;
				end
			end
			// Array registers the lookup here
			MS_LOOKUP: state <= MS_REPLY;
			MS_REPLY: begin
				if (!fetch_ack_o) begin
					if (rd_hit_i) begin
						fetch_ack_o  <= 1'b1;
						fetch_data_o <= rd_data_i;
						fetch_err_o  <= rd_err_i;
					end else begin
						beat_q   <= '0;
						line_err <= MEM_OK;
						state    <= MS_FILL_REQ;
					end
				end else if (!fetch_req_i) begin
					fetch_ack_o <= 1'b0;
					state       <= MS_IDLE;
				end
			end
			MS_FILL_REQ: begin
				// New beat only after the previous ack is gone
				if (!bus.ack) begin
					req_q  <= 1'b1;
					lock_q <= 1'b1;
					state  <= MS_FILL_ACK;
				end
			end
			MS_FILL_ACK: begin
				if (bus.ack) begin
					req_q              <= 1'b0;
					line_words[beat_q] <= bus.rdata;
					// Any error cuts the burst short
					if (bus.err != MEM_OK) begin
						line_err <= bus.err;
						state    <= MS_WRITE;
					end else if (beat_q == LAST_BEAT) begin
						state <= MS_WRITE;
					end else begin
						beat_q <= beat_q + 1'b1;
						state  <= MS_FILL_REQ;
					end
				end
			end
			MS_WRITE: begin
				// Lock released with the last ack low, then look up again
				if (!bus.ack) begin
					lock_q       <= 1'b0;
					miss_count_o <= miss_count_o + 32'd1;
					state        <= MS_LOOKUP;
				end
			end
			MS_INVAL: begin
				// First cycle clears the line, second raises the ack
				if (!inv_en_o && !inv_ack_o) begin
					inv_ack_o <= 1'b1;
				end else if (inv_ack_o && !inv_req_i) begin
					inv_ack_o <= 1'b0;
					state     <= MS_IDLE;
				end
			end
			default: state <= MS_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/ifetch_macros.svh
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// ======================================================================
// Fetch subsystem sizes
// ======================================================================

// Byte address width on the fetch, load and memory sides
`define IF_ADR_W 16

// Instruction and data word width
`define IF_WORD_W 32

// Direct-mapped L1, number of lines
`define IF_LINES 16

// Words per cache line, a line covers 16 bytes
`define IF_LINE_WORDS 4

// Address split, byte offset in the line / line index / tag
`define IF_OFS_W 4
`define IF_IDX_W 4
`define IF_TAG_W (`IF_ADR_W - `IF_IDX_W - `IF_OFS_W)

// Filler stored in every word of a line whose fill failed
`define IF_NOP_WORD 32'h0000_0013

`endif

//--- verilog/ifetch_pkg.sv
`include "ifetch_macros.svh"

package ifetch_pkg;

	// Completion code from memory, also kept per cache line
	typedef enum logic [1:0] {
		MEM_OK       = 2'd0,
		MEM_BUS_ERR  = 2'd1,
		MEM_PROT_ERR = 2'd2
	} mem_err_e;

	// Miss controller FSM
	typedef enum logic [2:0] {
		MS_IDLE,
		MS_LOOKUP,
		MS_REPLY,
		MS_FILL_REQ,
		MS_FILL_ACK,
		MS_WRITE,
		MS_INVAL
	} miss_state_e;

	// Uncached load port FSM
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_BUS,
		LD_REPLY
	} ld_state_e;

	// Arbiter, either free or holding a grant
	typedef enum logic {
		ARB_IDLE,
		ARB_GRANT
	} arb_state_e;

	// One L1 line, the error code sits above the words
	typedef struct packed {
		mem_err_e                                 err;
		logic [`IF_LINE_WORDS-1:0][`IF_WORD_W-1:0] words;
	} icache_line_t;

endpackage

//--- verilog/ifetch_top.sv
`include "ifetch_macros.svh"

module ifetch_top (
	input  logic                  clk,
	input  logic                  rst_i,
	// Fetch port
	input  logic                  fetch_req_i,
	input  logic [`IF_ADR_W-1:0]  fetch_adr_i,
	output logic                  fetch_ack_o,
	output logic [`IF_WORD_W-1:0] fetch_data_o,
	output ifetch_pkg::mem_err_e  fetch_err_o,
	// Load port
	input  logic                  ld_req_i,
	input  logic [`IF_ADR_W-1:0]  ld_adr_i,
	output logic                  ld_ack_o,
	output logic [`IF_WORD_W-1:0] ld_data_o,
	output ifetch_pkg::mem_err_e  ld_err_o,
	// Invalidate
	input  logic                  inv_req_i,
	input  logic [`IF_ADR_W-1:0]  inv_adr_i,
	output logic                  inv_ack_o,
	output logic [31:0]           miss_count_o,
	// Memory pins
	output logic                  mem_req_o,
	output logic [`IF_ADR_W-1:0]  mem_adr_o,
	input  logic                  mem_ack_i,
	input  logic [`IF_WORD_W-1:0] mem_rdata_i,
	input  ifetch_pkg::mem_err_e  mem_err_i
);
	import ifetch_pkg::*;

	// Miss controller to L1 array
	logic [`IF_ADR_W-1:0]  rd_adr;
	logic                  rd_hit;
	logic [`IF_WORD_W-1:0] rd_data;
	mem_err_e              rd_err;
	logic                  wr_en;
	logic [`IF_ADR_W-1:0]  wr_adr;
	icache_line_t          wr_line;
	logic                  inv_en;
	logic [`IF_ADR_W-1:0]  inv_adr;

	mem_bus_if fill_bus ();
	mem_bus_if ld_bus ();
	mem_bus_if mem_bus ();

	// Arbiter output onto the pins
	assign mem_req_o     = mem_bus.req;
	assign mem_adr_o     = mem_bus.adr;
	assign mem_bus.ack   = mem_ack_i;
	assign mem_bus.rdata = mem_rdata_i;
	assign mem_bus.err   = mem_err_i;

	l1_icache u_l1 (
		.clk       (clk),
		.rst_i     (rst_i),
		.rd_adr_i  (rd_adr),
		.rd_hit_o  (rd_hit),
		.rd_data_o (rd_data),
		.rd_err_o  (rd_err),
		.wr_en_i   (wr_en),
		.wr_adr_i  (wr_adr),
		.wr_line_i (wr_line),
		.inv_en_i  (inv_en),
		.inv_adr_i (inv_adr)
	);

	icache_miss_ctrl u_miss (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.fetch_ack_o  (fetch_ack_o),
		.fetch_data_o (fetch_data_o),
		.fetch_err_o  (fetch_err_o),
		.inv_req_i    (inv_req_i),
		.inv_adr_i    (inv_adr_i),
		.inv_ack_o    (inv_ack_o),
		.miss_count_o (miss_count_o),
		.rd_adr_o     (rd_adr),
		.rd_hit_i     (rd_hit),
		.rd_data_i    (rd_data),
		.rd_err_i     (rd_err),
		.wr_en_o      (wr_en),
		.wr_adr_o     (wr_adr),
		.wr_line_o    (wr_line),
		.inv_en_o     (inv_en),
		.inv_adr_o    (inv_adr),
		.bus          (fill_bus.master)
	);

	load_port u_load (
		.clk       (clk),
		.rst_i     (rst_i),
		.ld_req_i  (ld_req_i),
		.ld_adr_i  (ld_adr_i),
		.ld_ack_o  (ld_ack_o),
		.ld_data_o (ld_data_o),
		.ld_err_o  (ld_err_o),
		.bus       (ld_bus.master)
	);

	bus_arbiter u_arb (
		.clk      (clk),
		.rst_i    (rst_i),
		.fill_bus (fill_bus.slave),
		.ld_bus   (ld_bus.slave),
		.mem      (mem_bus.master)
	);

endmodule

//--- verilog/l1_icache.sv
`include "ifetch_macros.svh"

module l1_icache (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic [`IF_ADR_W-1:0]    rd_adr_i,
	output logic                    rd_hit_o,
	output logic [`IF_WORD_W-1:0]   rd_data_o,
	output ifetch_pkg::mem_err_e    rd_err_o,
	input  logic                    wr_en_i,
	input  logic [`IF_ADR_W-1:0]    wr_adr_i,
	input  ifetch_pkg::icache_line_t wr_line_i,
	input  logic                    inv_en_i,
	input  logic [`IF_ADR_W-1:0]    inv_adr_i
);
	import ifetch_pkg::*;

	localparam int WSEL_W = $clog2(`IF_LINE_WORDS);

	// ======================================================================
	// Storage
	// ======================================================================
	logic [`IF_LINES-1:0] valid;
	logic [`IF_TAG_W-1:0] tag_mem [`IF_LINES];
	icache_line_t         line_mem [`IF_LINES];

	// Address fields per port
	logic [`IF_IDX_W-1:0] rd_idx, wr_idx, inv_idx;
	logic [`IF_TAG_W-1:0] rd_tag, wr_tag, inv_tag;
	logic [WSEL_W-1:0]    rd_wsel;

	assign rd_idx  = rd_adr_i[`IF_OFS_W +: `IF_IDX_W];
	assign rd_tag  = rd_adr_i[`IF_ADR_W-1 -: `IF_TAG_W];
	// Word within the line, byte lanes dropped
	assign rd_wsel = rd_adr_i[2 +: WSEL_W];
	assign wr_idx  = wr_adr_i[`IF_OFS_W +: `IF_IDX_W];
	assign wr_tag  = wr_adr_i[`IF_ADR_W-1 -: `IF_TAG_W];
	assign inv_idx = inv_adr_i[`IF_OFS_W +: `IF_IDX_W];
	assign inv_tag = inv_adr_i[`IF_ADR_W-1 -: `IF_TAG_W];

	// Valid bits, write sets, matching invalidate clears
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid <= '0;
		end else begin
			if (wr_en_i)
				valid[wr_idx] <= 1'b1;
			// Only drop the line if it really holds this address
			if (inv_en_i && tag_mem[inv_idx] == inv_tag)
				valid[inv_idx] <= 1'b0;
		end
	end

	// Tag and data arrays, whole line in one cycle
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_mem[wr_idx]  <= wr_tag;
			line_mem[wr_idx] <= wr_line_i;
		end
	end

	// ======================================================================
	// Registered lookup
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst_i)
			rd_hit_o <= 1'b0;
		else
			rd_hit_o <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	end

	// Word and line code, meaningful only with a hit
	always_ff @(posedge clk) begin
		rd_data_o <= line_mem[rd_idx].words[rd_wsel];
		rd_err_o  <= line_mem[rd_idx].err;
	end

endmodule

//--- verilog/load_port.sv
`include "ifetch_macros.svh"

module load_port (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  ld_req_i,
	input  logic [`IF_ADR_W-1:0]  ld_adr_i,
	output logic                  ld_ack_o,
	output logic [`IF_WORD_W-1:0] ld_data_o,
	output ifetch_pkg::mem_err_e  ld_err_o,
	mem_bus_if.master             bus
);
	import ifetch_pkg::*;

	ld_state_e            state;
	logic [`IF_ADR_W-1:0] adr_q;
	logic                 req_q;

	// Single beats, never locked
	assign bus.req  = req_q;
	assign bus.lock = 1'b0;
	assign bus.adr  = adr_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state    <= LD_IDLE;
			ld_ack_o <= 1'b0;
			req_q    <= 1'b0;
		end else begin
			case (state)
			LD_IDLE: begin
				if (ld_req_i) begin
					adr_q <= ld_adr_i;
					state <= LD_BUS;
				end
			end
			LD_BUS: begin
				if (!req_q) begin
					// Wait out a trailing ack from the last load
					if (!bus.ack)
						req_q <= 1'b1;
				end else if (bus.ack) begin
					req_q     <= 1'b0;
					ld_data_o <= bus.rdata;
					ld_err_o  <= bus.err;
					ld_ack_o  <= 1'b1;
					state     <= LD_REPLY;
				end
			end
			LD_REPLY: begin
				// Hold the word until the processor lets go
				if (!ld_req_i) begin
					ld_ack_o <= 1'b0;
					state    <= LD_IDLE;
				end
			end
			default: state <= LD_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/mem_bus_if.sv
`include "ifetch_macros.svh"

// One requester's view of the memory bus
// Four-phase req/ack per beat, lock spans a burst
interface mem_bus_if;
	import ifetch_pkg::*;

	// Requester side
	logic                  req;
	logic                  lock;
	logic [`IF_ADR_W-1:0]  adr;

	// Responder side, rdata and err valid while ack is high
	logic                  ack;
	logic [`IF_WORD_W-1:0] rdata;
	mem_err_e              err;

	modport master (
		output req,
		output lock,
		output adr,
		input  ack,
		input  rdata,
		input  err
	);

	modport slave (
		input  req,
		input  lock,
		input  adr,
		output ack,
		output rdata,
		output err
	);

endinterface
